// ==== hdl/bch_gf_pkg.sv ====
package bch_gf_pkg;

	localparam int max_m = 8;

	typedef logic [max_m-1:0] elem_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [max_m:0] prim_poly(input int m);
		case (m)
			3: return 9'h00b;	// x^3+x+1.
			4: return 9'h013;	// x^4+x+1.
			5: return 9'h025;	// x^5+x^2+1.
			6: return 9'h043;	// x^6+x+1.
			7: return 9'h089;	// x^7+x^3+1.
			default: return 9'h11d;	// x^8+x^4+x^3+x^2+1.
		endcase
	endfunction

	function automatic elem_t gf_mul(input elem_t a, input elem_t b, input int m);
		logic [max_m:0] acc;
		acc = '0;
		for (int i = max_m - 1; i >= 0; i--) begin
			acc = acc << 1;
			if (acc[m])
				acc = acc ^ prim_poly(m);	// reduce on overflow.
			if (b[i])
				acc = acc ^ {1'b0, a};
		end
		return acc[max_m-1:0];
	endfunction

	function automatic elem_t alpha_pow(input int e, input int m);
		int n;
		int r;
		logic [max_m:0] acc;
		n = (1 << m) - 1;
		r = e % n;
		if (r < 0)
			r = r + n;	// negative powers wrap.
		acc = 1;
		for (int i = 0; i < (1 << max_m); i++) begin
			if (i < r) begin
				acc = acc << 1;
				if (acc[m])
					acc = acc ^ prim_poly(m);
			end
		end
		return acc[max_m-1:0];
	endfunction

endpackage

// ==== hdl/bch_code_pkg.sv ====
package bch_code_pkg;

	localparam int n_default = 15;
	localparam int k_default = 5;
	localparam int t_default = 3;	// correctable errors.

	// smallest m with 2^m - 1 >= n.
	function automatic int field_width(input int n);
		int m;
		m = 0;
		for (int i = 16; i >= 1; i--) begin
			if ((1 << i) - 1 >= n)
				m = i;
		end
		return m;
	endfunction

	// one syndrome per root alpha^1 .. alpha^2t.
	function automatic int syn_count(input int t);
		return 2 * t;
	endfunction

endpackage

// ==== hdl/bch_syndrome.sv ====
module bch_syndrome #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  logic               data_in,
	input  logic               ready,
	output logic               busy,
	output logic               valid,
	output logic [2*T*M-1:0]   syndromes
);

	localparam int len = (1 << M) - 1;	// full-length codeword.
	localparam int cw = $clog2(len);

	logic              take;
	logic [cw-1:0]     count;
	bch_gf_pkg::elem_t bit_in;
	bch_gf_pkg::elem_t odd_syn [T];
	bch_gf_pkg::elem_t all_syn [1:2*T];

	assign take = start && !busy && !valid;
	assign bit_in = bch_gf_pkg::elem_t'(data_in);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			valid <= 1'b0;
			count <= '0;
		end else if (take) begin
			busy <= 1'b1;
			count <= cw'(1);	// first bit comes with start.
		end else if (busy) begin
			count <= count + 1'b1;
			if (count == cw'(len - 1)) begin
				busy <= 1'b0;
				valid <= 1'b1;
			end
		end else if (valid && ready) begin
			valid <= 1'b0;
		end
	end

	// horner step per odd syndrome, S = S * alpha^j + r.
	for (genvar i = 0; i < T; i++) begin : g_odd
		localparam bch_gf_pkg::elem_t step = bch_gf_pkg::alpha_pow(2 * i + 1, M);
		bch_gf_pkg::elem_t acc;

		always_ff @(posedge clk) begin
			if (take)
				acc <= bit_in;
			else if (busy)
				acc <= bch_gf_pkg::gf_mul(acc, step, M) ^ bit_in;
		end

		assign odd_syn[i] = acc;
	end

	// even syndromes follow from S2j = Sj^2.
	always_comb begin
		for (int j = 1; j <= 2 * T; j++) begin
			if (j % 2 == 1)
				all_syn[j] = odd_syn[(j - 1) / 2];
			else
				all_syn[j] = bch_gf_pkg::gf_mul(all_syn[j / 2], all_syn[j / 2], M);
			syndromes[(j - 1) * M +: M] = all_syn[j][M-1:0];
		end
	end

endmodule

// ==== hdl/bch_key.sv ====
module bch_key #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_in,
	input  logic [2*T*M-1:0]     syndromes,
	output logic                 ready_in,
	output logic                 valid,
	output logic [(T+1)*M-1:0]   sigma,
	input  logic                 ready
);

	localparam int rw = T > 1 ? $clog2(T) : 1;
	localparam int kw = $clog2(2 * T + 1) + 2;
	localparam logic signed [kw-1:0] k_step = 2;

	logic                   busy;
	logic                   phase;	// 0 discrepancy, 1 update.
	logic                   accept;
	logic                   swap;
	logic [rw-1:0]          iter;
	logic signed [kw-1:0]   k;
	bch_gf_pkg::elem_t      syn [1:2*T];
	bch_gf_pkg::elem_t      lambda [T+1];	// locator being built.
	bch_gf_pkg::elem_t      corr [T+1];	// correction polynomial.
	bch_gf_pkg::elem_t      lambda_n [T+1];
	bch_gf_pkg::elem_t      corr_n [T+1];
	bch_gf_pkg::elem_t      gamma;
	bch_gf_pkg::elem_t      delta;
	bch_gf_pkg::elem_t      delta_c;

	assign ready_in = !busy && !valid;
	assign accept = valid_in && ready_in;
	assign swap = (delta != '0) && !k[kw-1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		int idx;
		delta_c = '0;
		for (int i = 0; i <= T; i++) begin
			idx = 2 * int'(iter) + 1 - i;
			if (idx >= 1)
				delta_c = delta_c ^ bch_gf_pkg::gf_mul(lambda[i], syn[idx], M);
		end
	end

	// lambda' = gamma*lambda + delta*x*corr.
	always_comb begin
		lambda_n[0] = bch_gf_pkg::gf_mul(gamma, lambda[0], M);
		for (int i = 1; i <= T; i++)
			lambda_n[i] = bch_gf_pkg::gf_mul(gamma, lambda[i], M) ^
				bch_gf_pkg::gf_mul(delta, corr[i - 1], M);
		corr_n[0] = '0;
		corr_n[1] = swap ? lambda[0] : '0;
		for (int i = 2; i <= T; i++)
			corr_n[i] = swap ? lambda[i - 1] : corr[i - 2];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			valid <= 1'b0;
			phase <= 1'b0;
			iter <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			phase <= 1'b1;	// first discrepancy is taken on accept.
			iter <= '0;
		end else if (busy) begin
			phase <= !phase;
			if (phase) begin
				if (iter == rw'(T - 1)) begin
					busy <= 1'b0;
					valid <= 1'b1;
				end else begin
					iter <= iter + 1'b1;
				end
			end
		end else if (valid && ready) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int j = 1; j <= 2 * T; j++)
				syn[j] <= bch_gf_pkg::elem_t'(syndromes[(j - 1) * M +: M]);
			for (int i = 0; i <= T; i++) begin
				lambda[i] <= (i == 0) ? bch_gf_pkg::elem_t'(1) : '0;
				corr[i] <= (i == 0) ? bch_gf_pkg::elem_t'(1) : '0;
			end
			gamma <= bch_gf_pkg::elem_t'(1);
			k <= '0;
			delta <= bch_gf_pkg::elem_t'(syndromes[M-1:0]);	// S1.
		end else if (busy && !phase) begin
			delta <= delta_c;
		end else if (busy && phase) begin
			lambda <= lambda_n;
			corr <= corr_n;
			if (swap) begin
				gamma <= delta;
				k <= -k;
			end else begin
				k <= k + k_step;	// even step folded in.
			end
		end
	end

	always_comb begin
		for (int i = 0; i <= T; i++)
			sigma[i * M +: M] = lambda[i][M-1:0];
	end

endmodule

// ==== hdl/bch_chien.sv ====
module bch_chien #(
	parameter int N = 15,
	parameter int M = 4,
	parameter int K = 5,
	parameter int T = 3
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_in,
	input  logic [(T+1)*M-1:0]   sigma,
	output logic                 ready_in,
	output logic                 err_valid,
	output logic                 err
);

	localparam int cw = K > 1 ? $clog2(K) : 1;

	logic              accept;
	logic [cw-1:0]     count;
	bch_gf_pkg::elem_t term [T+1];
	bch_gf_pkg::elem_t sum;

	assign ready_in = !err_valid;
	assign accept = valid_in && ready_in;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			err_valid <= 1'b0;
			count <= '0;
		end else if (accept) begin
			err_valid <= 1'b1;
			count <= '0;
		end else if (err_valid) begin
			count <= count + 1'b1;
			if (count == cw'(K - 1))
				err_valid <= 1'b0;	// message positions done.
		end
	end

	// term j starts at sigma_j * alpha^(-j(N-1)), the first received bit.
	for (genvar j = 0; j <= T; j++) begin : g_term
		localparam bch_gf_pkg::elem_t init = bch_gf_pkg::alpha_pow(-j * (N - 1), M);
		localparam bch_gf_pkg::elem_t step = bch_gf_pkg::alpha_pow(j, M);
		bch_gf_pkg::elem_t acc;

		always_ff @(posedge clk) begin
			if (accept)
				acc <= bch_gf_pkg::gf_mul(bch_gf_pkg::elem_t'(sigma[j * M +: M]), init, M);
			else if (err_valid)
				acc <= bch_gf_pkg::gf_mul(acc, step, M);	// next lower degree.
		end

		assign term[j] = acc;
	end

	always_comb begin
		sum = '0;
		for (int j = 0; j <= T; j++)
			sum = sum ^ term[j];
		err = (sum == '0);	// root found, bit is in error.
	end

endmodule

// ==== hdl/bch_decode.sv ====
module bch_decode #(
	parameter int N = bch_code_pkg::n_default,
	parameter int K = bch_code_pkg::k_default,
	parameter int T = bch_code_pkg::t_default,
	parameter int M = bch_code_pkg::field_width(N)
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic data_in,
	output logic ready,
	output logic output_valid,
	output logic data_out
);

	localparam int s_count = bch_code_pkg::syn_count(T);

	logic                 syn_busy;
	logic                 syn_valid;
	logic                 key_ready;
	logic                 key_valid;
	logic                 chien_ready;
	logic                 err_valid;
	logic                 err;
	logic                 take;
	logic [s_count*M-1:0] syndromes;
	logic [(T+1)*M-1:0]   sigma;
	logic [N-1:0]         buf_in;
	logic [K-1:0]         buf_key;
	logic [K-1:0]         buf_err;

	// a finished syndrome waiting on the key stage holds off new input.
	assign ready = !syn_busy && !syn_valid;
	assign take = start && ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	bch_syndrome #(.M(M), .T(T)) u_syndrome (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.ready(key_ready),
		.busy(syn_busy),
		.valid(syn_valid),
		.syndromes(syndromes)
	);

	bch_key #(.M(M), .T(T)) u_key (
		.clk(clk),
		.reset(reset),
		.valid_in(syn_valid),
		.syndromes(syndromes),
		.ready_in(key_ready),
		.valid(key_valid),
		.sigma(sigma),
		.ready(chien_ready)
	);

	bch_chien #(.N(N), .M(M), .K(K), .T(T)) u_chien (
		.clk(clk),
		.reset(reset),
		.valid_in(key_valid),
		.sigma(sigma),
		.ready_in(chien_ready),
		.err_valid(err_valid),
		.err(err)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (take || syn_busy)
			buf_in <= {buf_in[N-2:0], data_in};
		if (syn_valid && key_ready)
			buf_key <= buf_in[N-1 -: K];	// message is the first K bits.
		if (key_valid && chien_ready)
			buf_err <= buf_key;
		else if (err_valid)
			buf_err <= {buf_err[K-2:0], 1'b0};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			output_valid <= 1'b0;
			data_out <= 1'b0;
		end else begin
			output_valid <= err_valid;
			data_out <= err_valid && (buf_err[K-1] ^ err);	// corrected bit.
		end
	end

endmodule

// ==== testbench/bch_decode_assertions.sv ====
module bch_decode_assertions #(
	parameter int K = 5
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic ready,
	input  logic output_valid,
	input  logic data_out
);
	timeunit 1ns;
	timeprecision 1ps;

	int run;	// output_valid cycles in a row so far.
	int start_errs = 0;
	int data_errs = 0;
	int run_errs = 0;
	int fired;

	assign fired = start_errs + data_errs + run_errs;

	always_ff @(posedge clk) begin
		if (reset)
			run <= 0;
		else if (output_valid)
			run <= run + 1;
		else
			run <= 0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	start_needs_ready: assert property (@(posedge clk) disable iff (reset) start |-> ready)
		else begin
			start_errs++;
			$error("start was high while ready was low");
		end

	quiet_data: assert property (@(posedge clk) disable iff (reset) !output_valid |-> !data_out)
		else begin
			data_errs++;
			$error("data_out was high without output_valid");
		end

	message_length: assert property (@(posedge clk) disable iff (reset) output_valid |-> run < K)
		else begin
			run_errs++;
			$error("output_valid stayed high longer than one message");
		end

endmodule

bind bch_decode bch_decode_assertions #(.K(K)) u_assertions (
	.clk(clk),
	.reset(reset),
	.start(start),
	.ready(ready),
	.output_valid(output_valid),
	.data_out(data_out)
);

// ==== testbench/bch_decode_tb.sv ====
module bch_decode_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n = bch_code_pkg::n_default;
	localparam int k = bch_code_pkg::k_default;
	localparam int t = bch_code_pkg::t_default;
	localparam string cases_file = "testbench/bch_decode_cases.txt";
	localparam int gap_limit = 3;	// idle cycles between codewords.
	localparam int tight_cases = 4;	// leading codewords sent back to back.

	logic clk;
	logic reset;
	logic start;
	logic data_in;
	logic ready;
	logic output_valid;
	logic data_out;

	logic [n-1:0] cw_list [$];
	logic [k-1:0] msg_list [$];
	int           err_list [$];
	int           seed = 32'hdd78_a91f;
	int           num_cases;
	int           cycles;
	int           limit;
	bit           loaded;
	int           failures;
	int           passed;
	int           done_cases;
	int           pulses;
	int           got_bits;
	logic [k-1:0] got_msg;

	bch_decode dut0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.ready(ready),
		.output_valid(output_valid),
		.data_out(data_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic load_cases();
		int fd;
		int fields;
		string line;
		logic [31:0] cw_val;
		logic [31:0] msg_val;
		int errs;
		fd = $fopen(cases_file, "r");
		if (fd == 0) begin
			$display("could not open the cases file %s", cases_file);
			failures++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line[0] == "#")
				continue;	// column notes.
			fields = $sscanf(line, "%h %h %h", cw_val, msg_val, errs);
			if (fields == 3) begin
				cw_list.push_back(cw_val[n-1:0]);
				msg_list.push_back(msg_val[k-1:0]);
				err_list.push_back(errs);
			end
		end
		$fclose(fd);
		num_cases = cw_list.size();
	endtask

	// highest-degree bit first, start rides with it.
	task automatic send_codeword(input logic [n-1:0] cw, input int gap);
		wait (ready === 1'b1);
		repeat (gap) @(posedge clk);
		start <= 1'b1;
		data_in <= cw[n-1];
		for (int i = n - 2; i >= 0; i--) begin
			@(posedge clk);
			start <= 1'b0;
			data_in <= cw[i];
		end
		@(posedge clk);
		data_in <= 1'b0;
	endtask

	task automatic check_message();
		if (done_cases >= num_cases) begin
			$display("a message %h came out after the last case", got_msg);
			failures++;
		end else if (got_msg !== msg_list[done_cases]) begin
			$display("ERROR case %0d: data_out expected %h got %h",
				done_cases, msg_list[done_cases], got_msg);
			failures++;
		end else begin
			$display("case %0d: %0d errors, message %h ok",
				done_cases, err_list[done_cases], got_msg);
			passed++;
		end
		done_cases++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin
		if (!reset && output_valid === 1'b1) begin
			pulses++;
			got_msg = {got_msg[k-2:0], data_out};
			got_bits++;
			if (got_bits == k) begin
				check_message();
				got_bits = 0;
			end
		end
	end

	initial begin
		wait (loaded);
		limit = num_cases * (n + 2 * t + k + 3 + 8) * 2;
		if (limit < 100)
			limit = 100;	// room for reset and drain.
		cycles = 0;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int gap;
		reset = 1'b1;
		start = 1'b0;
		data_in = 1'b0;
		load_cases();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (ready !== 1'b1) begin
			$display("ERROR reset: ready expected %h got %h", 1'b1, ready);
			failures++;
		end else if (output_valid !== 1'b0) begin
			$display("ERROR reset: output_valid expected %h got %h", 1'b0, output_valid);
			failures++;
		end else begin
			$display("reset: ready and output_valid ok");
		end
		@(posedge clk);
		for (int i = 0; i < num_cases; i++) begin
			gap = (i < tight_cases) ? 0 : int'($unsigned($random(seed)) % (gap_limit + 1));
			send_codeword(cw_list[i], gap);
		end
		wait (done_cases >= num_cases);
		repeat (n + 2 * t + k) @(posedge clk);	// catch stray output bits.
		if (pulses != k * num_cases) begin
			$display("ERROR output_valid pulse count expected %h got %h",
				k * num_cases, pulses);
			failures++;
		end
		if (dut0.u_assertions.fired != 0) begin
			$display("%0d assertion failures were seen on the DUT", dut0.u_assertions.fired);
			failures++;
		end
		$display("cases %0d, passed %0d, failures %0d, output bits %0d",
			num_cases, passed, failures, pulses);
		if (failures == 0 && num_cases > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== testbench/bch_decode_cases.txt ====
# received codeword (15 bit hex, highest degree first), expected message (5 bit hex),
# number of injected bit errors (hex)
0000 00 0
0537 01 0
614d 18 0
3fff 1f 1
5371 14 1
1c39 17 2
3fd6 08 3
40d9 10 3
160a 0d 2
13a4 06 3
053b 01 2
2349 18 3
0400 00 1
1ffe 1f 3

// ==== bch_decode.f ====
hdl/bch_gf_pkg.sv
hdl/bch_code_pkg.sv
hdl/bch_syndrome.sv
hdl/bch_key.sv
hdl/bch_chien.sv
hdl/bch_decode.sv
testbench/bch_decode_assertions.sv
testbench/bch_decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the BCH decoder testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f bch_decode.f --top-module bch_decode_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# keep running past assertion errors so the testbench can report them
output=$(./obj_dir/Vbch_decode_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
